// ==== vlog.f ====
+incdir+rtl
rtl/trace_pkg.sv
rtl/trace_fetch.sv
rtl/trace_decode.sv
rtl/trace_back_stage.sv
rtl/trace_retire.sv
rtl/trace_pipeline_top.sv
verif/tb_trace_pipeline.sv

// ==== Makefile ====
# Verilator flow for the trace pipeline testbench

TOP := tb_trace_pipeline

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" sim.log

obj_dir/V$(TOP): vlog.f rtl/trace_params.svh rtl/*.sv verif/*.sv
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f vlog.f

lint:
	verilator --lint-only -Wall +incdir+rtl --top-module trace_pipeline_top \
		rtl/trace_pkg.sv rtl/trace_fetch.sv rtl/trace_decode.sv \
		rtl/trace_back_stage.sv rtl/trace_retire.sv rtl/trace_pipeline_top.sv

clean:
	rm -rf obj_dir sim.log

// ==== verif/tb_trace_pipeline.sv ====
// Instruction trace pipeline testbench
// Random issue bursts, stall windows and isolated flushes run against
// a cycle model of the five trace slots. Immediate assertions check
// every retired record, its latency and the retirement count

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module tb_trace_pipeline;

    import trace_pkg::*;

    localparam int STIM_CYCLES = 400;  // Random phase length
    localparam int ISSUE_CAP   = 240;  // Stay below the id wrap

    logic                      clk, rst, issue, stall, flush;
    logic [`TRACE_INSTR_W-1:0] instr;
    logic [`TRACE_EVT_W-1:0]   fetch_evt, decode_evt, execute_evt, mem_evt, wb_evt;
    logic                      retire_valid;
    logic [`TRACE_ID_W-1:0]    retire_id;
    logic [`TRACE_INSTR_W-1:0] retire_instr;
    logic [`TRACE_EVT_W-1:0]   retire_fetch_evt, retire_decode_evt, retire_exec_evt;
    logic [`TRACE_EVT_W-1:0]   retire_mem_evt, retire_wb_evt;
    logic [`TRACE_STALL_W-1:0] retire_stalls;
    logic [15:0]               retired_count;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////////////////////

    trace_rec_t exp_rec   [0:255];     // Expected record per accepted issue
    int         issue_cyc [0:255];
    int         hold_cyc  [0:255];     // Cycles held in fetch or decode
    bit         killed_id [0:255];
    int         live_q    [$];         // Surviving entries, oldest first
    bit         f_v, d_v, x_v, m_v, w_v, r_v;  // Slot valids
    int         f_i, d_i, x_i, m_i, w_i;       // Slot entries
    int cyc = 0, n_acc = 0, n_killed = 0, model_count = 0;
    int val_errs = 0, seq_errs = 0, issue_pulses = 0, wd_cycles = 0;
    int burst_left = 0, stall_left = 0, flush_gap = 0;
    bit long_done = 1'b0;

    trace_pipeline_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            val_errs++;
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
        end
    endtask

    function automatic logic [`TRACE_EVT_W-1:0] rand_evt();
        logic [31:0] r;
        r = $urandom();
        return r[`TRACE_EVT_W-1:0];
    endfunction

    // Flushed entries are always the youngest survivors
    task automatic kill_entry(input int idx);
        killed_id[exp_rec[idx].id] = 1'b1;
        n_killed++;
        live_q.delete(live_q.size() - 1);
    endtask

    // One rising edge of the model; inputs are still the ones the edge saw
    task automatic step_model();
        cyc++;
        r_v = w_v;
        if (w_v) begin
            exp_rec[w_i].wb_evt = wb_evt;
            model_count++;                          // Count moves as wb is left
        end
        if (m_v) exp_rec[m_i].mem_evt = mem_evt;
        w_v = m_v;
        w_i = m_i;
        if (x_v) exp_rec[x_i].exec_evt = execute_evt;
        m_v = x_v;
        m_i = x_i;
        x_v = d_v && !stall && !flush;              // Bubble under stall
        x_i = d_i;
        if (x_v) exp_rec[d_i].decode_evt = decode_evt;
        if (flush) begin
            if (d_v) kill_entry(d_i);
            if (f_v) kill_entry(f_i);
            d_v = 1'b0;
            f_v = 1'b0;
        end else if (stall) begin
            if (d_v) begin
                if (exp_rec[d_i].stalls != '1)
                    exp_rec[d_i].stalls = exp_rec[d_i].stalls + 1'b1;
                hold_cyc[d_i]++;
            end
            if (f_v) hold_cyc[f_i]++;
        end else begin
            if (f_v) begin
                exp_rec[f_i].instr     = instr;     // Word seen on decode entry
                exp_rec[f_i].fetch_evt = fetch_evt;
            end
            d_v = f_v;
            d_i = f_i;
            f_v = issue;
            f_i = n_acc;
            if (issue) begin
                exp_rec[n_acc]    = '0;
                exp_rec[n_acc].id = n_acc[`TRACE_ID_W-1:0];  // Id from accepted count
                issue_cyc[n_acc]  = cyc;
                hold_cyc[n_acc]   = 0;
                live_q.push_back(n_acc);
                n_acc++;
            end
        end
    endtask

    task automatic check_outputs();
        int idx;
        if (n_acc == 0 || cyc < issue_cyc[0] + 5) begin
            assert (retire_valid === 1'b0 && retired_count === '0) else begin
                seq_errs++;
                $display("Retire activity at cycle %0d before any instr could retire", cyc);
            end
        end
        check_val("retired_count", model_count, 32'(retired_count));
        assert (retire_valid === r_v) else begin
            seq_errs++;
            if (r_v)
                $display("Missing retirement at cycle %0d", cyc);
            else
                $display("Unexpected retirement of id %0d at cycle %0d", retire_id, cyc);
        end
        if (r_v && live_q.size() > 0 && retire_valid === 1'b1) begin
            idx = live_q.pop_front();                // Oldest survivor
            assert (!killed_id[retire_id]) else begin
                seq_errs++;
                $display("Flushed id %0d retired at cycle %0d", retire_id, cyc);
            end
            check_val("retire_id", exp_rec[idx].id, retire_id);
            check_val("retire_instr", exp_rec[idx].instr, retire_instr);
            check_val("retire_fetch_evt", exp_rec[idx].fetch_evt, retire_fetch_evt);
            check_val("retire_decode_evt", exp_rec[idx].decode_evt, retire_decode_evt);
            check_val("retire_exec_evt", exp_rec[idx].exec_evt, retire_exec_evt);
            check_val("retire_mem_evt", exp_rec[idx].mem_evt, retire_mem_evt);
            check_val("retire_wb_evt", exp_rec[idx].wb_evt, retire_wb_evt);
            check_val("retire_stalls", exp_rec[idx].stalls, retire_stalls);
            check_val("latency", 5 + hold_cyc[idx], cyc - issue_cyc[idx]);
        end
    endtask

    // Falling edge stimulus: bursts, stall windows of 1 to 6, lone flushes
    task automatic drive_inputs(input bit active, input int k);
        instr       = $urandom();
        fetch_evt   = rand_evt();
        decode_evt  = rand_evt();
        execute_evt = rand_evt();
        mem_evt     = rand_evt();
        wb_evt      = rand_evt();
        if (!active || n_acc >= ISSUE_CAP) begin
            issue = 1'b0;
        end else if (burst_left > 0) begin
            issue = 1'b1;
            burst_left--;
        end else if ($urandom_range(0, 5) == 0) begin
            issue      = 1'b1;
            burst_left = $urandom_range(0, 4);
        end else begin
            issue = ($urandom_range(0, 3) == 0);
        end
        if (!active) begin
            stall = 1'b0;
        end else if (k >= 200 && !long_done && d_v) begin
            stall      = 1'b1;                      // Long hold to saturate stalls
            stall_left = 17;
            long_done  = 1'b1;
        end else if (stall_left > 0) begin
            stall = 1'b1;
            stall_left--;
        end else begin
            stall      = ($urandom_range(0, 9) == 0);
            stall_left = stall ? $urandom_range(0, 5) : 0;
        end
        flush = active && flush_gap >= 8 && ($urandom_range(0, 19) == 0);
        flush_gap = flush ? 0 : flush_gap + 1;
        issue_pulses += issue;
    endtask

    initial begin : main_seq
        int k;
        void'($urandom(83));
        rst = 1'b1;
        issue = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        instr = '0;
        {fetch_evt, decode_evt, execute_evt, mem_evt, wb_evt} = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (k = 0; k < STIM_CYCLES; k++) begin
            drive_inputs(1'b1, k);
            @(negedge clk);
            step_model();
            check_outputs();
        end
        // Drain until every model slot is empty
        while (f_v || d_v || x_v || m_v || w_v || r_v) begin
            drive_inputs(1'b0, 0);
            @(negedge clk);
            step_model();
            check_outputs();
        end
        check_val("final retired_count", n_acc - n_killed, 32'(retired_count));
        $display("Errors: %0d value, %0d retirement (%0d issued, %0d flushed)",
                 val_errs, seq_errs, n_acc, n_killed);
        if (val_errs == 0 && seq_errs == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // Watchdog, limit grows with every issue pulse
    initial begin : watchdog
        @(posedge clk);
        while (wd_cycles < 20 * issue_pulses + 200) begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("Timeout: pipeline did not drain after %0d cycles", wd_cycles);
        $display("Errors: %0d value, %0d retirement", val_errs, seq_errs);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/trace_pipeline_top.sv ====
// Instruction trace pipeline top
// Chains fetch, decode, execute, memory and write-back trace slots
// beside the CPU and presents each retired record on one strobe

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module trace_pipeline_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      issue,
    input  wire logic [`TRACE_INSTR_W-1:0]  instr,
    input  wire logic [`TRACE_EVT_W-1:0]    fetch_evt,
    input  wire logic [`TRACE_EVT_W-1:0]    decode_evt,
    input  wire logic [`TRACE_EVT_W-1:0]    execute_evt,
    input  wire logic [`TRACE_EVT_W-1:0]    mem_evt,
    input  wire logic [`TRACE_EVT_W-1:0]    wb_evt,
    input  wire logic                      stall,
    input  wire logic                      flush,
    output logic                           retire_valid,
    output logic [`TRACE_ID_W-1:0]         retire_id,
    output logic [`TRACE_INSTR_W-1:0]      retire_instr,
    output logic [`TRACE_EVT_W-1:0]        retire_fetch_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_decode_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_exec_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_mem_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_wb_evt,
    output logic [`TRACE_STALL_W-1:0]      retire_stalls,
    output logic [15:0]                    retired_count
);

    import trace_pkg::*;

    // Stage boundaries: valid level plus record
    logic       fetch_valid, dec_valid, exec_valid, mem_valid;
    trace_rec_t fetch_rec, dec_rec, exec_rec, mem_rec;

    ////////////////////////////////////////////////////////////////////////////
    // Front end, the only stages that see stall and flush
    ////////////////////////////////////////////////////////////////////////////

    trace_fetch fetch_i (
        .clk(clk), .rst(rst), .issue(issue), .stall(stall), .flush(flush),
        .fetch_evt(fetch_evt), .fetch_valid(fetch_valid), .fetch_rec(fetch_rec)
    );

    trace_decode decode_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .instr(instr),
        .decode_evt(decode_evt), .in_valid(fetch_valid), .in_rec(fetch_rec),
        .dec_valid(dec_valid), .dec_rec(dec_rec)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Back end, one cycle per stage
    ////////////////////////////////////////////////////////////////////////////

    trace_back_stage #(.STAGE(STAGE_EXEC)) exec_i (
        .clk(clk), .rst(rst), .stage_evt(execute_evt), .in_valid(dec_valid),
        .in_rec(dec_rec), .out_valid(exec_valid), .out_rec(exec_rec)
    );

    trace_back_stage #(.STAGE(STAGE_MEM)) mem_i (
        .clk(clk), .rst(rst), .stage_evt(mem_evt), .in_valid(exec_valid),
        .in_rec(exec_rec), .out_valid(mem_valid), .out_rec(mem_rec)
    );

    trace_retire retire_i (
        .clk(clk), .rst(rst), .wb_evt(wb_evt), .in_valid(mem_valid), .in_rec(mem_rec),
        .retire_valid(retire_valid), .retire_id(retire_id), .retire_instr(retire_instr),
        .retire_fetch_evt(retire_fetch_evt), .retire_decode_evt(retire_decode_evt),
        .retire_exec_evt(retire_exec_evt), .retire_mem_evt(retire_mem_evt),
        .retire_wb_evt(retire_wb_evt), .retire_stalls(retire_stalls),
        .retired_count(retired_count)
    );

endmodule

`default_nettype wire

// ==== rtl/trace_retire.sv ====
// Trace retire slot
// Holds the write-back slot, then registers the finished record with
// the write-back event and pulses retire_valid for one cycle.
// Keeps a wrapping count of retirements

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module trace_retire (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic [`TRACE_EVT_W-1:0]    wb_evt,
    input  wire logic                      in_valid,      // From memory
    input  trace_pkg::trace_rec_t          in_rec,
    output logic                           retire_valid,  // One cycle per instr
    output logic [`TRACE_ID_W-1:0]         retire_id,
    output logic [`TRACE_INSTR_W-1:0]      retire_instr,
    output logic [`TRACE_EVT_W-1:0]        retire_fetch_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_decode_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_exec_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_mem_evt,
    output logic [`TRACE_EVT_W-1:0]        retire_wb_evt,
    output logic [`TRACE_STALL_W-1:0]      retire_stalls,
    output logic [15:0]                    retired_count
);

    import trace_pkg::*;

    logic       wb_valid_q;   // Instruction sits in write-back
    logic       ret_valid_q;
    trace_rec_t wb_rec_q;
    trace_rec_t done_rec;     // Write-back record plus its event
    trace_rec_t ret_rec_q;    // Presented record

    always_comb begin
        done_rec        = wb_rec_q;
        done_rec.wb_evt = wb_evt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q    <= 1'b0;
            ret_valid_q   <= 1'b0;
            retired_count <= '0;
        end else begin
            wb_valid_q  <= in_valid;
            ret_valid_q <= wb_valid_q;                      // Strobe after leaving wb
            if (wb_valid_q)
                retired_count <= retired_count + 1'b1;  // Wraps at 16 bits
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            wb_rec_q <= in_rec;
        if (wb_valid_q)
            ret_rec_q <= done_rec;
    end

    // Record fields out as loose retire ports
    assign retire_valid      = ret_valid_q;
    assign retire_id         = ret_rec_q.id;
    assign retire_instr      = ret_rec_q.instr;
    assign retire_fetch_evt  = ret_rec_q.fetch_evt;
    assign retire_decode_evt = ret_rec_q.decode_evt;
    assign retire_exec_evt   = ret_rec_q.exec_evt;
    assign retire_mem_evt    = ret_rec_q.mem_evt;
    assign retire_wb_evt     = ret_rec_q.wb_evt;
    assign retire_stalls     = ret_rec_q.stalls;

endmodule

`default_nettype wire

// ==== rtl/trace_back_stage.sv ====
// Trace back stage slot
// One-cycle slot for execute or memory. Never stalls; STAGE picks the
// event field that is filled as the instruction passes through

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module trace_back_stage #(
    parameter trace_pkg::trace_stage_e STAGE = trace_pkg::STAGE_EXEC
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [`TRACE_EVT_W-1:0] stage_evt,  // This stage's event code
    input  wire logic                   in_valid,
    input  trace_pkg::trace_rec_t       in_rec,
    output logic                        out_valid,
    output trace_pkg::trace_rec_t       out_rec
);

    import trace_pkg::*;

    logic       valid_q;
    trace_rec_t slot_q;

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else
            valid_q <= in_valid;   // Always advances
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            slot_q <= in_rec;
    end

    // Event of the single cycle spent here, sampled by the next stage
    always_comb begin
        out_rec = slot_q;
        if (STAGE == STAGE_EXEC)
            out_rec.exec_evt = stage_evt;
        else
            out_rec.mem_evt = stage_evt;
    end

    assign out_valid = valid_q;

endmodule

`default_nettype wire

// ==== rtl/trace_decode.sv ====
// Trace decode slot
// Latches the instruction word on entry, counts stall cycles with
// saturation and adds the decode event on exit. A stall sends a bubble
// to execute, a flush empties the slot

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module trace_decode (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     stall,
    input  wire logic                     flush,
    input  wire logic [`TRACE_INSTR_W-1:0] instr,       // Word of the arriving instr
    input  wire logic [`TRACE_EVT_W-1:0]   decode_evt,
    input  wire logic                     in_valid,    // From fetch
    input  trace_pkg::trace_rec_t         in_rec,
    output logic                          dec_valid,   // To execute
    output trace_pkg::trace_rec_t         dec_rec
);

    import trace_pkg::*;

    localparam logic [`TRACE_STALL_W-1:0] STALL_MAX = '1;

    logic       valid_q;
    trace_rec_t slot_q;
    trace_rec_t arrive_rec;   // Record as loaded on entry

    always_comb begin
        arrive_rec        = in_rec;
        arrive_rec.instr  = instr;
        arrive_rec.stalls = '0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            valid_q <= 1'b0;
        else if (flush)
            valid_q <= 1'b0;      // Flushed instr never retires
        else if (!stall)
            valid_q <= in_valid;  // Advance or take a bubble from fetch
    end

    // Payload, stall count only moves while an instruction is held
    always_ff @(posedge clk) begin
        if (!flush) begin
            if (stall) begin
                if (valid_q && slot_q.stalls != STALL_MAX)
                    slot_q.stalls <= slot_q.stalls + 1'b1;
            end else if (in_valid) begin
                slot_q <= arrive_rec;
            end
        end
    end

    // Bubble while stalled, nothing offered during a flush either
    assign dec_valid = valid_q && !stall && !flush;

    always_comb begin
        dec_rec            = slot_q;
        dec_rec.decode_evt = decode_evt;  // Value of the last decode cycle
    end

endmodule

`default_nettype wire

// ==== rtl/trace_fetch.sv ====
// Trace fetch slot
// Hands out sequence ids to issued instructions and holds the fetch
// record. Holds under stall, empties on flush, adds the fetch event
// on the way out

`timescale 1ns/1ps
`default_nettype none

`include "trace_params.svh"

module trace_fetch (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   issue,        // Instruction enters fetch
    input  wire logic                   stall,
    input  wire logic                   flush,        // Wins over stall
    input  wire logic [`TRACE_EVT_W-1:0] fetch_evt,
    output logic                        fetch_valid,
    output trace_pkg::trace_rec_t       fetch_rec
);

    import trace_pkg::*;

    logic                   accept;      // Issue that actually takes an id
    logic [`TRACE_ID_W-1:0] id_cnt;      // Next id to hand out
    logic                   valid_q;
    trace_rec_t             slot_q;      // Record of the instruction in fetch
    trace_rec_t             fresh_rec;

    assign accept = issue && !stall && !flush;  // Issue ignored under stall/flush

    // Blank record carrying only the new id
    always_comb begin
        fresh_rec    = '0;
        fresh_rec.id = id_cnt;
    end

    // Control state, id counter free runs and wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            id_cnt  <= '0;
        end else begin
            if (flush)
                valid_q <= 1'b0;    // Killed, id stays consumed
            else if (!stall)
                valid_q <= issue;   // Old occupant moves to decode
            if (accept)
                id_cnt <= id_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            slot_q <= fresh_rec;
    end

    // Live fetch event rides along, decode samples it at the departure edge
    always_comb begin
        fetch_rec           = slot_q;
        fetch_rec.fetch_evt = fetch_evt;
    end

    assign fetch_valid = valid_q;

endmodule

`default_nettype wire

// ==== rtl/trace_pkg.sv ====
// Trace pipeline types
// Record that travels beside the instruction through the five stages,
// plus the selector that tells a back stage which event field it owns

`default_nettype none

`include "trace_params.svh"

package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Trace record
    ////////////////////////////////////////////////////////////////////////////

    // Filled in stage by stage, complete when it leaves write-back
    typedef struct packed {
        logic [`TRACE_ID_W-1:0]    id;          // Sequence id from fetch
        logic [`TRACE_INSTR_W-1:0] instr;       // Latched on decode entry
        logic [`TRACE_EVT_W-1:0]   fetch_evt;   // Last fetch cycle
        logic [`TRACE_EVT_W-1:0]   decode_evt;  // Last decode cycle
        logic [`TRACE_EVT_W-1:0]   exec_evt;    // Execute cycle
        logic [`TRACE_EVT_W-1:0]   mem_evt;     // Memory cycle
        logic [`TRACE_EVT_W-1:0]   wb_evt;      // Write-back cycle
        logic [`TRACE_STALL_W-1:0] stalls;      // Saturating stall count
    } trace_rec_t;

    ////////////////////////////////////////////////////////////////////////////
    // Back stage selector
    ////////////////////////////////////////////////////////////////////////////

    // Which event field a trace_back_stage writes
    typedef enum logic {
        STAGE_EXEC = 1'b0,
        STAGE_MEM  = 1'b1
    } trace_stage_e;

endpackage

`default_nettype wire

// ==== rtl/trace_params.svh ====
// Trace pipeline widths
// Shared sizes for sequence ids, stage event codes, the instruction
// word and the saturating stall counter of the trace record

`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Record field widths
////////////////////////////////////////////////////////////////////////////

// Sequence id, wraps after 2**TRACE_ID_W issues
`define TRACE_ID_W     8

// Event code reported by each stage
`define TRACE_EVT_W    8

`define TRACE_INSTR_W  32  // Full instruction word

// Stall cycles seen in decode, saturates at all ones
`define TRACE_STALL_W  4

`endif
